//--- Makefile
TOP = mem_ctrl_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- sim/bus_slave_model.sv
/* memory slave for the testbench, 4 KB with random wait states
   bok follows burst_en_i so line fills can be forced to single cycles */
`timescale 1ns/10ps

module bus_slave_model (
	input  logic clk,
	input  logic rst,
	input  logic burst_en_i,
	input  memctl_pkg::bus_req_t bus_i,
	output memctl_pkg::bus_rsp_t bus_o
);

	logic [7:0] mem [4096];
	logic [31:0] lfsr;
	logic [31:0] lfsr_n1;	// one step ahead
	logic busy;
	logic [1:0] wait_cnt;
	logic ack_q;
	logic [127:0] dat_q;
	logic [11:0] base;

	// galois form, one step per random bit
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	initial begin
		for (int a = 0; a < 4096; a++)
			mem[a] = 8'(a) ^ 8'(a >> 8);	// low byte xor high byte
	end

	assign lfsr_n1 = lfsr_step(lfsr);
	assign base = {bus_i.adr[11:4], 4'h0};

	always @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			busy <= 1'b0;
			wait_cnt <= '0;
			dat_q <= '0;
			lfsr <= 32'h8508_d374;
		end else if (ack_q) begin
			ack_q <= 1'b0;	// single cycle ack
		end else if (bus_i.cyc && bus_i.stb) begin
			if (!busy) begin
				busy <= 1'b1;
				wait_cnt <= {lfsr[0], lfsr_n1[0]};
				lfsr <= lfsr_step(lfsr_n1);
			end else if (wait_cnt == 2'd0) begin
				ack_q <= 1'b1;
				busy <= 1'b0;
				for (int k = 0; k < 16; k++) begin
					if (bus_i.we && bus_i.sel[k])
						mem[base + k] <= bus_i.dat[8*k +: 8];
					dat_q[8*k +: 8] <= mem[base + k];
				end
			end else begin
				wait_cnt <= wait_cnt - 1'b1;
			end
		end
	end

	assign bus_o.ack = ack_q;
	assign bus_o.bok = burst_en_i;
	assign bus_o.dat = dat_q;

endmodule

//--- sim/mem_ctrl_tb.sv
/* testbench for mem_ctrl_top, runs the commands in sim/test_input.txt
   against a shadow memory and checks responses, fills and bus beats */
`timescale 1ns/10ps

module mem_ctrl_tb;

	logic clk = 1'b0;
	logic rst;
	logic req_wr;
	memctl_pkg::mem_req_t req;
	logic req_full;
	logic resp_rd;
	memctl_pkg::mem_resp_t resp;
	logic resp_empty;
	logic [31:0] ip;
	logic ihit;
	logic [511:0] ic_line;
	memctl_pkg::bus_req_t bus_req;
	memctl_pkg::bus_rsp_t bus_rsp;
	logic burst_en;

	logic [7:0] shadow [4096];
	memctl_pkg::mem_resp_t exp_q [$];
	memctl_pkg::mem_resp_t exp_head;
	int errors = 0;
	int checks = 0;
	int test_errs = 0;
	int resp_cnt = 0;
	int vpa_beats = 0;
	int vpa_pulses = 0;
	logic prev_vpa_stb = 1'b0;
	logic hold = 1'b0;	// keep resp_rd low
	logic full_seen = 1'b0;
	int nlines = 0;

	always #2 clk = ~clk;

	mem_ctrl_top dut0 (
		.clk(clk), .rst(rst),
		.req_wr_i(req_wr), .req_i(req), .req_full_o(req_full),
		.resp_rd_i(resp_rd), .resp_o(resp), .resp_empty_o(resp_empty),
		.ip_i(ip), .ihit_o(ihit), .ic_line_o(ic_line),
		.bus_o(bus_req), .bus_i(bus_rsp)
	);

	bus_slave_model slave0 (
		.clk(clk), .rst(rst), .burst_en_i(burst_en),
		.bus_i(bus_req), .bus_o(bus_rsp)
	);

	task automatic check_val(input logic [511:0] got, input logic [511:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errs++;
			$display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic logic [63:0] load_value(input logic [11:0] adr, input logic [1:0] size,
		input logic uns);
		logic [63:0] v;
		int n;
		v = '0;
		n = 1 << size;
		for (int i = 0; i < n; i++)
			v[8*i +: 8] = shadow[12'(adr + i)];
		if (!uns && n < 8 && v[8*n-1])
			v = v | ~((64'd1 << (8*n)) - 64'd1);	// sign fill
		return v;
	endfunction

	function automatic logic [511:0] line_value(input logic [31:0] a);
		logic [511:0] ln;
		for (int k = 0; k < 64; k++)
			ln[8*k +: 8] = shadow[{a[11:6], 6'd0} + k];
		return ln;
	endfunction

	task automatic push_req(input memctl_pkg::mem_req_t r);
		int stall;
		stall = 0;
		while (req_full) begin
			if (hold) begin
				stall++;
				// req_full that long means the response queue is full too
				if (stall == 100) begin
					check_val(exp_q.size(), 2 * memctl_pkg::QDEPTH + 1,
						"requests outstanding with both queues full");	// +1 for r
					full_seen = 1'b1;
					hold = 1'b0;
				end
			end
			@(negedge clk);
		end
		req = r;
		req_wr = 1'b1;
		@(negedge clk);
		req_wr = 1'b0;
	endtask

	// ==================================================
	// bus beat counting and response checking
	// ==================================================
	always @(negedge clk) begin
		if (!rst) begin
			if (bus_req.vpa && bus_req.stb && bus_rsp.ack)
				vpa_beats++;
			if (bus_req.vpa && bus_req.stb && !prev_vpa_stb)
				vpa_pulses++;
			prev_vpa_stb = bus_req.vpa && bus_req.stb;
		end
	end

	always @(negedge clk) begin
		if (!rst && !hold && !resp_empty) begin
			if (exp_q.size() == 0) begin
				errors++;
				test_errs++;
				$display("response with tid %0h arrived but none was outstanding", resp.tid);
			end else begin
				exp_head = exp_q.pop_front();
				check_val(resp.tid, exp_head.tid, "response tid");
				check_val(resp.res, exp_head.res, "response result");
				resp_cnt++;
			end
			resp_rd = 1'b1;
		end else begin
			resp_rd = 1'b0;
		end
	end

	// whole run is bounded by the length of the command file
	initial begin
		wait (nlines > 0);
		#(nlines * 16000);
		$display("watchdog expired at %0t ns, the run did not finish", $time);
		$display("*** FAILED ***");
		$finish;
	end

	// ==================================================
	// command loop
	// ==================================================
	initial begin
		int fd;
		int test_no;
		int resp0;
		int beats0;
		int pulses0;
		int cyc;
		string line;
		logic [7:0] op;
		logic [63:0] f1, f2, f3, f4;
		logic f_in_test;
		logic f_miss;
		logic hold_req;
		memctl_pkg::mem_req_t r;
		memctl_pkg::mem_resp_t e;

		rst = 1'b1;
		req_wr = 1'b0;
		req = '0;
		resp_rd = 1'b0;
		ip = '0;
		burst_en = 1'b1;
		for (int a = 0; a < 4096; a++)
			shadow[a] = 8'(a) ^ 8'(a >> 8);

		fd = $fopen("sim/test_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/test_input.txt");
			$display("*** FAILED ***");
			$finish;
		end else begin
			while ($fgets(line, fd))
				nlines++;
			$fclose(fd);
			fd = $fopen("sim/test_input.txt", "r");

			repeat (5) @(negedge clk);
			rst = 1'b0;
			@(negedge clk);
			check_val(bus_req, memctl_pkg::BUS_IDLE, "bus idle after reset");
			check_val(resp_empty, 1'b1, "resp_empty_o after reset");
			check_val(req_full, 1'b0, "req_full_o after reset");
			check_val(ihit, 1'b0, "ihit_o after reset");

			test_no = 1;
			resp0 = 0;
			beats0 = vpa_beats;
			pulses0 = vpa_pulses;
			f_in_test = 1'b0;
			f_miss = 1'b0;
			hold_req = 1'b0;
			while ($fgets(line, fd)) begin
				f1 = '0;
				f2 = '0;
				f3 = '0;
				f4 = '0;
				void'($sscanf(line, "%c %h %h %h %h", op, f1, f2, f3, f4));
				r = '0;
				case (op)
				"L", "S": begin
					r.func = (op == "S") ? memctl_pkg::STORE : memctl_pkg::LOAD;
					r.adr = f1[31:0];
					r.size = memctl_pkg::size_e'(f2[1:0]);
					r.uns = (op == "L") ? f3[0] : 1'b0;
					r.tid = (op == "L") ? f4[3:0] : f3[3:0];
					r.dat = (op == "S") ? f4 : 64'd0;
					e.tid = r.tid;
					if (op == "S") begin
						e.res = 64'd0;
						for (int i = 0; i < (1 << f2[1:0]); i++)
							shadow[12'(f1 + i)] = f4[8*i +: 8];
					end else begin
						e.res = load_value(f1[11:0], f2[1:0], f3[0]);
					end
					exp_q.push_back(e);
					push_req(r);
				end
				"R":	// f1 octa loads from f2 upward
					for (int i = 0; i < f1; i++) begin
						r.func = memctl_pkg::LOAD;
						r.size = memctl_pkg::OCTA;
						r.adr = f2[31:0] + 32'(8 * i);
						r.tid = 4'(i);
						e.tid = r.tid;
						e.res = load_value(r.adr[11:0], 2'd3, 1'b0);
						exp_q.push_back(e);
						push_req(r);
					end
				"F": begin
					ip = f1[31:0];
					f_in_test = 1'b1;
					f_miss = f2[0];
					beats0 = vpa_beats;
					pulses0 = vpa_pulses;
					@(negedge clk);
					check_val(ihit, !f_miss, "ihit_o one cycle after ip change");
				end
				"M": burst_en = f1[0];
				"H": begin
					hold = f1[0];
					hold_req = f1[0];
					full_seen = 1'b0;
				end
				"W": begin
					hold = 1'b0;
					for (cyc = 0; cyc < 4000; cyc++) begin
						if (exp_q.size() == 0 && (!f_in_test || ihit))
							break;
						@(negedge clk);
					end
					if (cyc == 4000) begin
						errors++;
						test_errs++;
						$display("test %0d timed out waiting for responses or a line fill", test_no);
					end
					if (f_in_test) begin
						check_val(vpa_beats - beats0, f_miss ? 4 : 0, "acked vpa beats");
						if (f_miss)
							check_val(vpa_pulses - pulses0, burst_en ? 1 : 4, "vpa stb pulses");
						check_val(ic_line, line_value(ip), "icache line");
					end
					if (hold_req)
						check_val(full_seen, 1'b1, "both queues filled while responses held");
					$display("test %0d: %0d responses checked, %0d errors", test_no,
						resp_cnt - resp0, test_errs);
					test_no++;
					test_errs = 0;
					resp0 = resp_cnt;
					f_in_test = 1'b0;
					hold_req = 1'b0;
				end
				default: ;	// comment or blank line
				endcase
			end
			$fclose(fd);

			if (exp_q.size() != 0) begin
				errors++;
				$display("%0d responses never arrived", exp_q.size());
			end
			$display("%0d tests, %0d checks, %0d errors", test_no - 1, checks, errors);
			if (errors == 0)
				$display("*** PASSED ***");
			else
				$display("*** FAILED ***");
			$finish;
		end
	end

endmodule

//--- sim/test_input.txt
# L adr size uns tid | S adr size tid dat | R count adr | F ip miss
# M burst | H hold | W ends a test; numbers in hex, size 0..3 = byte..octa
F 000 1
W
S 208 3 1 8877665544332211
S 212 2 2 f00dbeef
S 21e 1 3 80a5
S 201 0 4 9c
L 208 3 0 5
L 20c 2 0 6
L 20c 2 1 7
L 21e 1 0 8
L 21e 1 1 9
L 201 0 0 a
L 201 0 1 b
L 3f0 3 1 c
W
F 440 1
W
M 0
F 880 1
L 100 3 0 1
L 105 0 0 2
L 212 2 0 3
W
F 8a4 0
W
M 1
H 1
R 14 300
W

//--- src.f
verilog/memctl_pkg.sv
verilog/fifo_buf.sv
verilog/icache.sv
verilog/ifetch_engine.sv
verilog/data_engine.sv
verilog/bus_arbiter.sv
verilog/mem_ctrl_top.sv
sim/bus_slave_model.sv
sim/mem_ctrl_tb.sv

//--- verilog/bus_arbiter.sv
/* shares the one bus between the fill engine and the data engine
   a grant lasts until the owner ends its cycle, data wins a tie */
`timescale 1ns/10ps

module bus_arbiter (
	input  logic clk,
	input  logic rst,
	input  logic fill_req_i,
	input  logic data_req_i,
	input  memctl_pkg::bus_req_t fill_bus_i,
	input  memctl_pkg::bus_req_t data_bus_i,
	output memctl_pkg::bus_req_t bus_o,
	output logic grant_fill_o,
	output logic grant_data_o
);

	typedef enum logic [1:0] {OWN_NONE, OWN_FILL, OWN_DATA} owner_e;

	owner_e owner;
	logic owner_cyc;
	logic cyc_q;	// owner's cyc last cycle

	always_comb begin
		case (owner)
		OWN_FILL: owner_cyc = fill_bus_i.cyc;
		OWN_DATA: owner_cyc = data_bus_i.cyc;
		default:  owner_cyc = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			owner <= OWN_NONE;
			cyc_q <= 1'b0;
		end else begin
			cyc_q <= owner_cyc;
			if (owner == OWN_NONE) begin
				if (data_req_i)
					owner <= OWN_DATA;
				else if (fill_req_i)
					owner <= OWN_FILL;
			end else if (cyc_q && !owner_cyc) begin	// cycle just ended
				owner <= OWN_NONE;
			end
		end
	end

	always_comb begin
		case (owner)
		OWN_FILL: bus_o = fill_bus_i;
		OWN_DATA: bus_o = data_bus_i;
		default:  bus_o = memctl_pkg::BUS_IDLE;
		endcase
	end

	assign grant_fill_o = (owner == OWN_FILL);
	assign grant_data_o = (owner == OWN_DATA);

	// engines must not open a cycle without holding the bus
	a_cyc_needs_grant: assert property (@(posedge clk) disable iff (rst)
		!(fill_bus_i.cyc && !grant_fill_o) && !(data_bus_i.cyc && !grant_data_o));

endmodule

//--- verilog/data_engine.sv
/* runs one data bus access per queued load or store, in order
   loads are aligned and extended here before the response is queued */
`timescale 1ns/10ps

module data_engine (
	input  logic clk,
	input  logic rst,
	input  memctl_pkg::mem_req_t req_i,
	input  logic req_empty_i,
	output logic req_rd_o,
	input  logic resp_full_i,
	output logic resp_wr_o,
	output memctl_pkg::mem_resp_t resp_o,
	output logic data_req_o,
	input  logic grant_i,
	output memctl_pkg::bus_req_t bus_o,
	input  memctl_pkg::bus_rsp_t bus_i
);

	typedef enum logic [1:0] {DE_IDLE, DE_REQ, DE_BUS, DE_RESP} de_state_e;

	de_state_e state;
	memctl_pkg::mem_req_t req_q;
	memctl_pkg::bus_req_t bus_q;
	logic [memctl_pkg::BUS_W-1:0] beat_q;	// captured read beat
	logic [memctl_pkg::BEAT_OFS-1:0] ofs;
	logic [memctl_pkg::SEL_W-1:0] size_mask;
	logic [memctl_pkg::SEL_W-1:0] sel;
	logic [memctl_pkg::BUS_W-1:0] st_dat;
	logic [memctl_pkg::BUS_W-1:0] ld_beat;
	logic [63:0] ld_raw;
	logic [63:0] ld_ext;
	logic pop;
	logic ack;

	assign ack = bus_i.ack & grant_i;
	assign pop = (state == DE_IDLE) && !req_empty_i && !resp_full_i;
	assign ofs = req_q.adr[memctl_pkg::BEAT_OFS-1:0];

	// ==================================================
	// lane steering
	// ==================================================
	always_comb begin
		case (req_q.size)
		memctl_pkg::BYTE:  size_mask = 16'h0001;
		memctl_pkg::WYDE:  size_mask = 16'h0003;
		memctl_pkg::TETRA: size_mask = 16'h000F;
		default:           size_mask = 16'h00FF;
		endcase
		sel = size_mask << ofs;
		st_dat = {64'd0, req_q.dat} << {ofs, 3'b000};
		ld_beat = beat_q >> {ofs, 3'b000};
		ld_raw = ld_beat[63:0];
	end

	always_comb begin
		case (req_q.size)
		memctl_pkg::BYTE:
			ld_ext = req_q.uns ? {56'd0, ld_raw[7:0]} : {{56{ld_raw[7]}}, ld_raw[7:0]};
		memctl_pkg::WYDE:
			ld_ext = req_q.uns ? {48'd0, ld_raw[15:0]} : {{48{ld_raw[15]}}, ld_raw[15:0]};
		memctl_pkg::TETRA:
			ld_ext = req_q.uns ? {32'd0, ld_raw[31:0]} : {{32{ld_raw[31]}}, ld_raw[31:0]};
		default:
			ld_ext = ld_raw;
		endcase
	end

	// ==================================================
	// access sequence
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= DE_IDLE;
			bus_q <= memctl_pkg::BUS_IDLE;
		end else begin
			case (state)
			DE_IDLE:
				if (pop) begin
					req_q <= req_i;
					state <= DE_REQ;
				end
			DE_REQ:
				if (grant_i && !ack) begin
					bus_q.cyc <= 1'b1;
					bus_q.stb <= 1'b1;
					bus_q.vda <= 1'b1;
					bus_q.we <= (req_q.func == memctl_pkg::STORE);
					bus_q.cti <= memctl_pkg::CTI_CLASSIC;
					bus_q.sel <= sel;
					bus_q.adr <= {req_q.adr[memctl_pkg::ADR_W-1:memctl_pkg::BEAT_OFS],
						{memctl_pkg::BEAT_OFS{1'b0}}};
					bus_q.dat <= (req_q.func == memctl_pkg::STORE) ? st_dat : '0;
					state <= DE_BUS;
				end
			DE_BUS:
				if (ack) begin
					beat_q <= bus_i.dat;
					bus_q <= memctl_pkg::BUS_IDLE;
					state <= DE_RESP;
				end
			DE_RESP:
				state <= DE_IDLE;	// response written this cycle
			default:
				state <= DE_IDLE;
			endcase
		end
	end

	assign req_rd_o = pop;
	assign data_req_o = pop || (state == DE_REQ) || (state == DE_BUS);
	assign bus_o = bus_q;
	assign resp_wr_o = (state == DE_RESP);
	assign resp_o.tid = req_q.tid;
	assign resp_o.res = (req_q.func == memctl_pkg::STORE) ? 64'd0 : ld_ext;	// stores return zero

endmodule

//--- verilog/fifo_buf.sv
/* first-word-fall-through queue, head valid while empty_o is low
   payload type is a parameter, so one body serves requests and responses */
`timescale 1ns/10ps

module fifo_buf #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 8
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     wr_i,
	input  payload_t din_i,
	input  logic     rd_i,
	output payload_t dout_o,
	output logic     empty_o,
	output logic     full_o
);

	localparam int AW = $clog2(DEPTH);

	payload_t mem [DEPTH];
	logic [AW-1:0] wptr;
	logic [AW-1:0] rptr;
	logic [AW:0] cnt;

	always_ff @(posedge clk) begin
		if (wr_i)
			mem[wptr] <= din_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wptr <= '0;
			rptr <= '0;
			cnt <= '0;
		end else begin
			if (wr_i)
				wptr <= (wptr == AW'(DEPTH - 1)) ? '0 : wptr + 1'b1;
			if (rd_i)
				rptr <= (rptr == AW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
			case ({wr_i, rd_i})
			2'b10: cnt <= cnt + 1'b1;
			2'b01: cnt <= cnt - 1'b1;
			default: ;	// both or neither, count holds
			endcase
		end
	end

	assign dout_o = mem[rptr];
	assign empty_o = (cnt == '0);
	assign full_o = (cnt == (AW + 1)'(DEPTH));

	// producer and consumer must honour the flags
	a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(wr_i && full_o));
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(rd_i && empty_o));

endmodule

//--- verilog/icache.sv
/* 4-way instruction cache with combinational lookup of ip_i
   lines are written by the fill engine into round-robin ways */
`timescale 1ns/10ps

module icache (
	input  logic clk,
	input  logic rst,
	input  logic [memctl_pkg::ADR_W-1:0] ip_i,
	output logic ihit_o,
	output logic [memctl_pkg::LINE_W-1:0] ic_line_o,
	input  logic fill_we_i,
	input  logic [memctl_pkg::ADR_W-1:0] fill_adr_i,
	input  logic [memctl_pkg::LINE_W-1:0] fill_line_i
);

	logic [memctl_pkg::TAG_W-1:0] tag_mem [memctl_pkg::WAYS][memctl_pkg::SETS];
	logic [memctl_pkg::LINE_W-1:0] line_mem [memctl_pkg::WAYS][memctl_pkg::SETS];
	logic [memctl_pkg::SETS-1:0] valid_q [memctl_pkg::WAYS];
	logic [memctl_pkg::WAY_W-1:0] rr_way;	// next way to replace

	logic [memctl_pkg::IDX_W-1:0] ip_idx;
	logic [memctl_pkg::TAG_W-1:0] ip_tag;
	logic [memctl_pkg::IDX_W-1:0] fill_idx;
	logic [memctl_pkg::TAG_W-1:0] fill_tag;
	logic [memctl_pkg::WAYS-1:0] hit;

	assign ip_idx = ip_i[memctl_pkg::LINE_OFS +: memctl_pkg::IDX_W];
	assign ip_tag = ip_i[memctl_pkg::ADR_W-1 -: memctl_pkg::TAG_W];
	assign fill_idx = fill_adr_i[memctl_pkg::LINE_OFS +: memctl_pkg::IDX_W];
	assign fill_tag = fill_adr_i[memctl_pkg::ADR_W-1 -: memctl_pkg::TAG_W];

	// ==================================================
	// lookup
	// ==================================================
	always_comb begin
		ic_line_o = '0;
		for (int w = 0; w < memctl_pkg::WAYS; w++) begin
			hit[w] = valid_q[w][ip_idx] && (tag_mem[w][ip_idx] == ip_tag);
			if (hit[w])
				ic_line_o = line_mem[w][ip_idx];
		end
	end

	assign ihit_o = |hit;

	// ==================================================
	// fill
	// ==================================================
	always_ff @(posedge clk) begin
		if (fill_we_i) begin
			tag_mem[rr_way][fill_idx] <= fill_tag;
			line_mem[rr_way][fill_idx] <= fill_line_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < memctl_pkg::WAYS; w++)
				valid_q[w] <= '0;
			rr_way <= '0;
		end else if (fill_we_i) begin
			valid_q[rr_way][fill_idx] <= 1'b1;
			rr_way <= rr_way + 1'b1;	// wraps over all ways
		end
	end

	// fill engine only loads lines that missed, so no line lives in two ways
	a_one_way_hits: assert property (@(posedge clk) disable iff (rst) $onehot0(hit));

endmodule

//--- verilog/ifetch_engine.sv
/* loads a missing icache line over the bus, burst first and single cycles if refused
   hands the finished line to the icache with a one-cycle write strobe */
`timescale 1ns/10ps

module ifetch_engine (
	input  logic clk,
	input  logic rst,
	input  logic [memctl_pkg::ADR_W-1:0] ip_i,
	input  logic ihit_i,
	output logic fill_req_o,
	input  logic grant_i,
	output memctl_pkg::bus_req_t bus_o,
	input  memctl_pkg::bus_rsp_t bus_i,
	output logic fill_we_o,
	output logic [memctl_pkg::ADR_W-1:0] fill_adr_o,
	output logic [memctl_pkg::LINE_W-1:0] fill_line_o
);

	typedef enum logic [2:0] {IF_IDLE, IF_REQ, IF_BEAT, IF_GAP, IF_WRITE} if_state_e;

	if_state_e state;
	memctl_pkg::bus_req_t bus_q;
	logic [memctl_pkg::ADR_W-1:0] line_adr;	// held for the whole fill
	logic [memctl_pkg::LINE_W-1:0] line_q;
	logic [memctl_pkg::BEAT_W-1:0] beat;
	logic [memctl_pkg::BEAT_W-1:0] beat_n;
	logic ack;

	assign ack = bus_i.ack & grant_i;	// ignore acks meant for the data engine
	assign beat_n = beat + 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IF_IDLE;
			bus_q <= memctl_pkg::BUS_IDLE;
			beat <= '0;
		end else begin
			case (state)
			IF_IDLE:
				if (!ihit_i) begin
					line_adr <= {ip_i[memctl_pkg::ADR_W-1:memctl_pkg::LINE_OFS],
						{memctl_pkg::LINE_OFS{1'b0}}};
					beat <= '0;
					state <= IF_REQ;
				end
			IF_REQ:
				if (grant_i && !ack) begin
					bus_q.cyc <= 1'b1;
					bus_q.stb <= 1'b1;
					bus_q.vpa <= 1'b1;
					bus_q.cti <= memctl_pkg::CTI_BURST;
					bus_q.sel <= '1;
					bus_q.adr <= line_adr;
					state <= IF_BEAT;
				end
			IF_BEAT:
				if (ack) begin
					line_q <= {bus_i.dat, line_q[memctl_pkg::LINE_W-1:memctl_pkg::BUS_W]};
					beat <= beat_n;
					bus_q.adr <= {line_adr[memctl_pkg::ADR_W-1:memctl_pkg::LINE_OFS], beat_n,
						{memctl_pkg::BEAT_OFS{1'b0}}};
					if (beat == memctl_pkg::LAST_BEAT) begin
						bus_q <= memctl_pkg::BUS_IDLE;
						state <= IF_WRITE;
					end else if (!bus_i.bok) begin	// slave refused the burst
						bus_q.stb <= 1'b0;
						bus_q.cti <= memctl_pkg::CTI_CLASSIC;
						state <= IF_GAP;
					end
				end
			IF_GAP:
				if (!ack) begin	// slave ready for the next single cycle
					bus_q.stb <= 1'b1;
					state <= IF_BEAT;
				end
			IF_WRITE:
				state <= IF_IDLE;
			default:
				state <= IF_IDLE;
			endcase
		end
	end

	assign bus_o = bus_q;
	assign fill_req_o = (state == IF_REQ) || (state == IF_BEAT) || (state == IF_GAP);
	assign fill_we_o = (state == IF_WRITE);
	assign fill_adr_o = line_adr;
	assign fill_line_o = line_q;

endmodule

//--- verilog/mem_ctrl_top.sv
/* memory controller top, request and response queues, icache, two bus engines
   and the arbiter that joins them on the single bus */
`timescale 1ns/10ps

module mem_ctrl_top (
	input  logic clk,
	input  logic rst,
	input  logic req_wr_i,
	input  memctl_pkg::mem_req_t req_i,
	output logic req_full_o,
	input  logic resp_rd_i,
	output memctl_pkg::mem_resp_t resp_o,
	output logic resp_empty_o,
	input  logic [memctl_pkg::ADR_W-1:0] ip_i,
	output logic ihit_o,
	output logic [memctl_pkg::LINE_W-1:0] ic_line_o,
	output memctl_pkg::bus_req_t bus_o,
	input  memctl_pkg::bus_rsp_t bus_i
);

	// ==================================================
	// internal wiring
	// ==================================================
	memctl_pkg::mem_req_t req_head;
	logic req_empty;
	logic req_rd;
	memctl_pkg::mem_resp_t resp_in;
	logic resp_wr;
	logic resp_full;
	logic fill_req;
	logic data_req;
	logic grant_fill;
	logic grant_data;
	memctl_pkg::bus_req_t fill_bus;
	memctl_pkg::bus_req_t data_bus;
	logic fill_we;
	logic [memctl_pkg::ADR_W-1:0] fill_adr;
	logic [memctl_pkg::LINE_W-1:0] fill_line;

	fifo_buf #(.payload_t(memctl_pkg::mem_req_t), .DEPTH(memctl_pkg::QDEPTH)) req_fifo0 (
		.clk(clk), .rst(rst),
		.wr_i(req_wr_i), .din_i(req_i),
		.rd_i(req_rd), .dout_o(req_head),
		.empty_o(req_empty), .full_o(req_full_o)
	);

	fifo_buf #(.payload_t(memctl_pkg::mem_resp_t), .DEPTH(memctl_pkg::QDEPTH)) resp_fifo0 (
		.clk(clk), .rst(rst),
		.wr_i(resp_wr), .din_i(resp_in),
		.rd_i(resp_rd_i), .dout_o(resp_o),
		.empty_o(resp_empty_o), .full_o(resp_full)
	);

	icache icache0 (
		.clk(clk), .rst(rst),
		.ip_i(ip_i), .ihit_o(ihit_o), .ic_line_o(ic_line_o),
		.fill_we_i(fill_we), .fill_adr_i(fill_adr), .fill_line_i(fill_line)
	);

	ifetch_engine ifetch0 (
		.clk(clk), .rst(rst),
		.ip_i(ip_i), .ihit_i(ihit_o),
		.fill_req_o(fill_req), .grant_i(grant_fill),
		.bus_o(fill_bus), .bus_i(bus_i),	// slave side goes to both engines
		.fill_we_o(fill_we), .fill_adr_o(fill_adr), .fill_line_o(fill_line)
	);

	data_engine data0 (
		.clk(clk), .rst(rst),
		.req_i(req_head), .req_empty_i(req_empty), .req_rd_o(req_rd),
		.resp_full_i(resp_full), .resp_wr_o(resp_wr), .resp_o(resp_in),
		.data_req_o(data_req), .grant_i(grant_data),
		.bus_o(data_bus), .bus_i(bus_i)
	);

	bus_arbiter arb0 (
		.clk(clk), .rst(rst),
		.fill_req_i(fill_req), .data_req_i(data_req),
		.fill_bus_i(fill_bus), .data_bus_i(data_bus),
		.bus_o(bus_o),
		.grant_fill_o(grant_fill), .grant_data_o(grant_data)
	);

endmodule

//--- verilog/memctl_pkg.sv
/* shared sizes, request/response records and bus records for the memory controller
   every block names these through memctl_pkg:: */

package memctl_pkg;

	// ==================================================
	// sizes
	// ==================================================
	localparam int ADR_W  = 32;
	localparam int BUS_W  = 128;	// one beat
	localparam int SEL_W  = 16;	// byte lanes per beat
	localparam int LINE_W = 512;	// icache line
	localparam int BEATS  = 4;	// beats per line
	localparam int SETS   = 16;
	localparam int WAYS   = 4;
	localparam int TID_W  = 4;
	localparam int QDEPTH = 8;

	// derived address fields
	localparam int BEAT_OFS = $clog2(BUS_W / 8);	// byte offset in a beat
	localparam int LINE_OFS = $clog2(LINE_W / 8);	// byte offset in a line
	localparam int BEAT_W   = $clog2(BEATS);
	localparam int IDX_W    = $clog2(SETS);
	localparam int WAY_W    = $clog2(WAYS);
	localparam int TAG_W    = ADR_W - LINE_OFS - IDX_W;
	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BEATS - 1);

	// cycle type codes
	localparam logic [2:0] CTI_CLASSIC = 3'b000;
	localparam logic [2:0] CTI_BURST   = 3'b001;

	// ==================================================
	// function codes and records
	// ==================================================
	typedef enum logic {LOAD = 1'b0, STORE = 1'b1} func_e;

	typedef enum logic [1:0] {BYTE = 2'd0, WYDE = 2'd1, TETRA = 2'd2, OCTA = 2'd3} size_e;

	typedef struct packed {
		func_e func;
		size_e size;
		logic uns;	// zero extend a load
		logic [TID_W-1:0] tid;
		logic [ADR_W-1:0] adr;
		logic [63:0] dat;
	} mem_req_t;

	typedef struct packed {
		logic [TID_W-1:0] tid;
		logic [63:0] res;
	} mem_resp_t;

	// master side of the bus
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic vpa;	// instruction access
		logic vda;	// data access
		logic [2:0] cti;
		logic [SEL_W-1:0] sel;
		logic [ADR_W-1:0] adr;
		logic [BUS_W-1:0] dat;
	} bus_req_t;

	// slave side
	typedef struct packed {
		logic ack;
		logic bok;	// burst accepted
		logic [BUS_W-1:0] dat;
	} bus_rsp_t;

	localparam bus_req_t BUS_IDLE = '0;

endpackage
